// ==== design/clmul_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// carry-less multiplier shared definitions
// widths and packed payload types for the karatsuba pipeline
//////////////////////////////////////////////////////////////////////

package clmul_pkg;

    localparam int NB_OP   = 64;            // operand width
    localparam int NB_HALF = NB_OP / 2;     // one karatsuba half
    localparam int NB_PART = 2*NB_HALF - 1; // half x half product, odd
    localparam int NB_PROD = 2*NB_PART + 1; // full product width
    localparam int N_PARTS = 3;             // low, middle, high

    // slot order inside the operand and partial arrays
    localparam int IDX_LO  = 0; // low halves
    localparam int IDX_MID = 1; // xor of high and low halves
    localparam int IDX_HI  = 2; // high halves

    // factor pair for one half-width core
    typedef struct packed {
        logic [NB_HALF-1:0] a;
        logic [NB_HALF-1:0] b;
    } half_pair_t;

    // one pair per core
    typedef half_pair_t [N_PARTS-1:0] koa_operands_t;

    // one partial product per core, same slot order
    typedef logic [N_PARTS-1:0][NB_PART-1:0] koa_partials_t;

endpackage

// ==== design/clmul_top.sv ====
//////////////////////////////////////////////////////////////////////
// pipelined 64 bit carry-less multiplier
// one karatsuba step over three half-width cores
//////////////////////////////////////////////////////////////////////

module clmul_top
#(
    parameter int N_STAGES          = 4,  // stages per core
    parameter int CREATE_OUTPUT_REG = 1   // merger output register
)
(
    input  logic                            i_clock,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  logic [clmul_pkg::NB_OP-1:0]     i_op_a,
    input  logic [clmul_pkg::NB_OP-1:0]     i_op_b,
    output logic                            o_valid,
    output logic [clmul_pkg::NB_PROD-1:0]   o_product
);

    import clmul_pkg::*;

    logic               split_valid;
    koa_operands_t      split_operands;
    logic [N_PARTS-1:0] core_valid;     // cores run in lockstep
    koa_partials_t      core_products;

    koa_splitter u_splitter
    (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_op_a     (i_op_a),
        .i_op_b     (i_op_b),
        .o_valid    (split_valid),
        .o_operands (split_operands)
    );

    for (genvar k = 0; k < N_PARTS; k++)
    begin : g_core
        gf2_clmul_core
        #(
            .N_STAGES (N_STAGES)
        )
        u_core
        (
            .i_clock   (i_clock),
            .i_rst_n   (i_rst_n),
            .i_valid   (split_valid),
            .i_pair    (split_operands[k]),
            .o_valid   (core_valid[k]),
            .o_product (core_products[k])
        );
    end

    koa_merger
    #(
        .CREATE_OUTPUT_REG (CREATE_OUTPUT_REG)
    )
    u_merger
    (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_valid    (core_valid[0]),   // any core strobe will do
        .i_partials (core_products),
        .o_valid    (o_valid),
        .o_product  (o_product)
    );

endmodule

// ==== design/gf2_clmul_core.sv ====
//////////////////////////////////////////////////////////////////////
// half-width carry-less multiplier core
// shift-and-xor product of two gf2 polynomials over N_STAGES stages
//////////////////////////////////////////////////////////////////////

module gf2_clmul_core
#(
    parameter int N_STAGES = 4  // must divide NB_HALF
)
(
    input  logic                            i_clock,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  clmul_pkg::half_pair_t           i_pair,
    output logic                            o_valid,
    output logic [clmul_pkg::NB_PART-1:0]   o_product
);

    import clmul_pkg::*;

    localparam int BITS_PER_STAGE = NB_HALF / N_STAGES;

    // everything one stage hands to the next
    typedef struct packed {
        logic [NB_HALF-1:0] a;      // factor a, never shifted
        logic [NB_HALF-1:0] b_rem;  // factor b bits not yet consumed
        logic [NB_PART-1:0] acc;    // running partial sum
    } stage_t;

    logic   valid_q [N_STAGES];
    stage_t stage_q [N_STAGES];

    if (NB_HALF % N_STAGES != 0)
    begin : g_bad_conf
        $error("N_STAGES must divide the half operand width");
    end

    for (genvar s = 0; s < N_STAGES; s++)
    begin : g_stage

        logic   valid_in;
        stage_t stage_in;
        stage_t stage_out;

        if (s == 0)
        begin : g_first
            assign valid_in = i_valid;
            assign stage_in = '{a: i_pair.a, b_rem: i_pair.b, acc: '0}; // empty acc
        end
        else
        begin : g_next
            assign valid_in = valid_q[s-1];
            assign stage_in = stage_q[s-1];
        end

        // consume BITS_PER_STAGE low bits of b_rem
        always_comb
        begin
            stage_out = stage_in;
            for (int j = 0; j < BITS_PER_STAGE; j++)
            begin
                // global bit index of b is s*BITS_PER_STAGE + j
                if (stage_in.b_rem[j])
                    stage_out.acc = stage_out.acc
                                  ^ (NB_PART'(stage_in.a) << (s*BITS_PER_STAGE + j));
            end
            stage_out.b_rem = stage_in.b_rem >> BITS_PER_STAGE; // next chunk to bit 0
        end

        always_ff @(posedge i_clock)
        begin
            if (!i_rst_n)
                valid_q[s] <= 1'b0;
            else
                valid_q[s] <= valid_in;
        end

        // payload follows its strobe
        always_ff @(posedge i_clock)
        begin
            if (valid_in)
                stage_q[s] <= stage_out;
        end

    end

    assign o_valid   = valid_q[N_STAGES-1];
    assign o_product = stage_q[N_STAGES-1].acc;   // all of b consumed here

    // every stage register loaded along the way
    a_product_known : assert property (
        @(posedge i_clock) disable iff (!i_rst_n) o_valid |-> !$isunknown(o_product)
    );

endmodule

// ==== design/koa_merger.sv ====
//////////////////////////////////////////////////////////////////////
// karatsuba merger
// folds low, middle and high partials into the full product
//////////////////////////////////////////////////////////////////////

module koa_merger
#(
    parameter int CREATE_OUTPUT_REG = 1  // nonzero adds an output register
)
(
    input  logic                            i_clock,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  clmul_pkg::koa_partials_t        i_partials,
    output logic                            o_valid,
    output logic [clmul_pkg::NB_PROD-1:0]   o_product
);

    import clmul_pkg::*;

    logic [NB_PART-1:0] part_lo;
    logic [NB_PART-1:0] part_mid;
    logic [NB_PART-1:0] part_hi;
    logic [NB_PART-1:0] part_cross;
    logic [NB_PROD-1:0] lo_ext;
    logic [NB_PROD-1:0] cross_ext;
    logic [NB_PROD-1:0] hi_ext;
    logic [NB_PROD-1:0] product_sum;

    assign part_lo  = i_partials[IDX_LO];
    assign part_mid = i_partials[IDX_MID];
    assign part_hi  = i_partials[IDX_HI];

    // middle term: (a_h+a_l)(b_h+b_l) - hh - ll, minus is xor
    assign part_cross = part_lo ^ part_mid ^ part_hi;

    assign lo_ext    = NB_PROD'(part_lo);                            // x^0
    assign cross_ext = {{NB_HALF{1'b0}}, part_cross, {NB_HALF{1'b0}}}; // x^32
    assign hi_ext    = {part_hi, {(NB_PART+1){1'b0}}};               // x^64

    assign product_sum = lo_ext ^ cross_ext ^ hi_ext;

    if (CREATE_OUTPUT_REG != 0)
    begin : g_out_reg

        always_ff @(posedge i_clock)
        begin
            if (!i_rst_n)
                o_valid <= 1'b0;
            else
                o_valid <= i_valid;
        end

        always_ff @(posedge i_clock)
        begin
            if (i_valid)
                o_product <= product_sum;   // hold between valid cycles
        end

    end
    else
    begin : g_out_comb

        assign o_valid   = i_valid;
        assign o_product = product_sum;

    end

    // strobe must be clean once the pipeline leaves reset
    a_valid_known : assert property (
        @(posedge i_clock) disable iff (!i_rst_n) !$isunknown(o_valid)
    );

endmodule

// ==== design/koa_splitter.sv ====
//////////////////////////////////////////////////////////////////////
// karatsuba operand splitter
// registers an operand pair, builds the three half-width pairs
//////////////////////////////////////////////////////////////////////

module koa_splitter
(
    input  logic                          i_clock,
    input  logic                          i_rst_n,
    input  logic                          i_valid,
    input  logic [clmul_pkg::NB_OP-1:0]   i_op_a,
    input  logic [clmul_pkg::NB_OP-1:0]   i_op_b,
    output logic                          o_valid,
    output clmul_pkg::koa_operands_t      o_operands
);

    import clmul_pkg::*;

    logic [NB_HALF-1:0] a_lo;
    logic [NB_HALF-1:0] a_hi;
    logic [NB_HALF-1:0] b_lo;
    logic [NB_HALF-1:0] b_hi;
    koa_operands_t      operands_next;

    assign a_lo = i_op_a[NB_HALF-1:0];
    assign a_hi = i_op_a[NB_OP-1:NB_HALF];
    assign b_lo = i_op_b[NB_HALF-1:0];
    assign b_hi = i_op_b[NB_OP-1:NB_HALF];

    always_comb
    begin
        operands_next[IDX_LO].a  = a_lo;
        operands_next[IDX_LO].b  = b_lo;
        operands_next[IDX_MID].a = a_lo ^ a_hi;   // (a_hi + a_lo) over gf2
        operands_next[IDX_MID].b = b_lo ^ b_hi;
        operands_next[IDX_HI].a  = a_hi;
        operands_next[IDX_HI].b  = b_hi;
    end

    // valid bit cleared by reset
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    // payload only moves on a valid input
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            o_operands <= operands_next;
    end

    // a valid pair leaves with every operand bit known
    a_operands_known : assert property (
        @(posedge i_clock) disable iff (!i_rst_n) o_valid |-> !$isunknown(o_operands)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_clmul_top -o tb_clmul_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_clmul_top > sim.log 2>&1
cat sim.log

grep -q "^Everything OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
design/clmul_pkg.sv
design/koa_splitter.sv
design/gf2_clmul_core.sv
design/koa_merger.sv
design/clmul_top.sv
testbench/tb_clmul_top.sv

// ==== testbench/tb_clmul_top.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the pipelined carry-less multiplier
// random and directed pairs checked against a bitwise gf2 model
//////////////////////////////////////////////////////////////////////

module tb_clmul_top;

    timeunit 1ns;
    timeprecision 1ps;

    import clmul_pkg::*;

    localparam real CLK_PERIOD  = 4.0;
    localparam real DRIVE_DELAY = 0.5;   // after the rising edge
    localparam int  LATENCY     = 6;     // splitter + 4 core stages + merger reg
    localparam int  N_DIRECTED  = 10;
    localparam int  N_RANDOM    = 2000;
    localparam int  N_DUTY      = 1000;
    localparam int  N_RESET     = 100;   // pre + post reset, idle and hold
    localparam int  N_ALG       = 100;   // triples
    localparam int  N_CYCLES    = 10 + N_DIRECTED + N_RANDOM + N_DUTY + N_RESET + 3*N_ALG;
    localparam int  MARGIN      = 500;   // drains and slack

    typedef struct packed {
        int                 due;    // cycle the result must show up
        logic [NB_PROD-1:0] prod;
    } expect_t;

    logic               clock;
    logic               rst_n;
    logic               in_valid;
    logic [NB_OP-1:0]   op_a;
    logic [NB_OP-1:0]   op_b;
    logic               out_valid;
    logic [NB_PROD-1:0] product;

    logic [31:0]        rng_state;
    int                 cyc;
    int                 checks;
    int                 errors;
    int                 test_checks;     // snapshot at test start
    int                 test_errors;
    logic               monitor_on;
    logic               due_now;
    expect_t            head;
    expect_t            exp_q [$];
    logic [NB_PROD-1:0] seen_q [$];      // every product seen on o_valid
    logic [NB_PROD-1:0] alg_q [$];       // model side of the algebraic check

    clmul_top u_clmul_top
    (
        .i_clock   (clock),
        .i_rst_n   (rst_n),
        .i_valid   (in_valid),
        .i_op_a    (op_a),
        .i_op_b    (op_b),
        .o_valid   (out_valid),
        .o_product (product)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    always @(posedge clock)
        cyc <= cyc + 1;

    // xorshift32, state kept in rng_state
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [NB_OP-1:0] random_operand();
        return {next_random(), next_random()};
    endfunction

    // plain shift-and-xor over all 64 bits, no split
    function automatic logic [NB_PROD-1:0] clmul_ref(input logic [NB_OP-1:0] a,
                                                     input logic [NB_OP-1:0] b);
        logic [NB_PROD-1:0] r;
        r = '0;
        for (int i = 0; i < NB_OP; i++)
        begin
            if (b[i])
                r = r ^ (NB_PROD'(a) << i);
        end
        return r;
    endfunction

    task automatic check_valid(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED time %0t: %s, o_valid %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_product(input logic [NB_PROD-1:0] got,
                                 input logic [NB_PROD-1:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED time %0t: %s, product %h expected %h", $time, what, got, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock)
    begin
        if (monitor_on)
        begin
            due_now = (exp_q.size() != 0) && (exp_q[0].due == cyc);
            check_valid(out_valid, due_now, "output strobe");
            if (due_now)
            begin
                head = exp_q.pop_front();
                if (out_valid)
                    check_product(product, head.prod, "product");
            end
            if (out_valid === 1'b1)
                seen_q.push_back(product);
        end
    end

    task automatic step();
        @(posedge clock);
        #(DRIVE_DELAY);
    endtask

    // one input cycle; a valid pair books its result LATENCY cycles on
    task automatic drive(input logic v, input logic [NB_OP-1:0] a, input logic [NB_OP-1:0] b);
        step();
        in_valid = v;
        op_a     = a;
        op_b     = b;
        if (v)
            exp_q.push_back('{due: cyc + LATENCY, prod: clmul_ref(a, b)});
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            drive(1'b0, '0, '0);
        repeat (3) drive(1'b0, '0, '0);   // nothing may trail behind
    endtask

    task automatic start_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic report_test(input string name);
        $display("%s done: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
    endtask

    initial
    begin
        #(CLK_PERIOD * (N_CYCLES + MARGIN));
        $display("timeout: the DUT did not deliver all results in time");
        $display("Something failed");
        $finish;
    end

    initial
    begin
        logic [NB_OP-1:0] a;
        logic [NB_OP-1:0] b;
        logic [NB_OP-1:0] c;
        logic [NB_OP-1:0] x;
        logic [NB_OP-1:0] ones;

        rng_state  = 32'h5161_cd69;
        cyc        = 0;
        checks     = 0;
        errors     = 0;
        monitor_on = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        op_a       = '0;
        op_b       = '0;
        ones       = '1;
        repeat (10) @(posedge clock);
        #(DRIVE_DELAY);
        rst_n      = 1'b1;
        monitor_on = 1'b1;

        start_test();
        x = random_operand();
        drive(1'b1, '0, '0);
        drive(1'b1, '0, ones);
        drive(1'b1, 64'd1, 64'd1);
        drive(1'b1, 64'd1, x);                       // identity
        drive(1'b1, ones, ones);
        drive(1'b1, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);  // top bit of product
        drive(1'b1, 64'h8000_0000_0000_0000, 64'd1);
        drive(1'b1, 64'h0000_0000_8000_0000, 64'h0000_0001_0000_0000); // across halves
        drive(1'b1, {x[31:0], x[31:0]}, {x[63:32], x[63:32]});          // middle term zero
        drive(1'b1, {x[31:0], x[31:0]}, ones);
        drain();
        report_test("directed corners");

        start_test();
        for (int i = 0; i < N_RANDOM; i++)
            drive(1'b1, random_operand(), random_operand());
        drain();
        report_test("random full rate");

        start_test();
        for (int i = 0; i < N_DUTY; i++)
            drive(next_random() % 4 != 0, random_operand(), random_operand()); // ~75% duty
        drain();
        report_test("random duty cycle");

        start_test();
        for (int i = 0; i < 30; i++)
            drive(1'b1, random_operand(), random_operand());
        step();
        rst_n    = 1'b0;                              // mid-stream, pipeline full
        in_valid = 1'b0;
        while (exp_q.size() != 0 && exp_q[$].due > cyc)
            void'(exp_q.pop_back());                  // these never leave the DUT
        repeat (4) step();
        rst_n = 1'b1;
        repeat (10) drive(1'b0, random_operand(), random_operand());
        for (int i = 0; i < 30; i++)
            drive(1'b1, random_operand(), random_operand());
        drain();
        report_test("reset mid-stream");

        start_test();
        seen_q.delete();
        for (int i = 0; i < N_ALG; i++)
        begin
            a = random_operand();
            b = random_operand();
            c = random_operand();
            drive(1'b1, a, b);
            drive(1'b1, a, c);
            drive(1'b1, a, b ^ c);
            alg_q.push_back(clmul_ref(a, b) ^ clmul_ref(a, c));
        end
        drain();
        if (seen_q.size() != 3*N_ALG)
        begin
            errors++;
            $display("algebraic check: expected %0d results but saw %0d",
                     3*N_ALG, seen_q.size());
        end
        else
        begin
            for (int i = 0; i < N_ALG; i++)
            begin
                check_product(seen_q[3*i+2], seen_q[3*i] ^ seen_q[3*i+1], "a(b^c) vs ab^ac");
                check_product(seen_q[3*i+2], alg_q[i], "a(b^c) vs model");
            end
        end
        report_test("distributive law");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
